/* Mmu.f */
source/MmuTypes.sv
source/FlipFlopCam.sv
source/Tlb.sv
source/PageWalker.sv
source/Mmu.sv
verif/Mmu_assertions.sv
verif/MmuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := MmuTb
RTL_TOP := Mmu
FILELIST := Mmu.f
FLAGS := --binary --timing --assert
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/MmuTb.sv */
module MmuTb import MmuTypes::*; ();
    localparam physicalPageNumberT RootPpn = 22'h000100;
    localparam physicalPageNumberT TablePpn = 22'h000200;
    localparam int LookupTimeout = 40;
    // Six tests of up to 20 lookups, each well under 25 cycles
    localparam int CycleLimit = 6 * 20 * 25;
    localparam logic [7:0] FlagValid = 8'h01;
    localparam logic [7:0] FlagRead = 8'h02;
    localparam logic [7:0] FlagWrite = 8'h04;
    localparam logic [7:0] FlagExec = 8'h08;
    localparam logic [7:0] FlagUser = 8'h10;
    localparam logic [7:0] FlagAccessed = 8'h40;
    localparam logic [7:0] FlagDirty = 8'h80;

    logic clk;
    logic rst;
    logic readEnable;
    virtualPageNumberT readKey;
    MemoryAccessType readAccessType;
    csrSatpT csrSatp;
    Privilege csrPrivilege;
    logic csrSum;
    logic csrMxr;
    logic invalidate;
    logic memReadValid;
    logic [31:0] memReadData;
    logic hit;
    logic fault;
    physicalPageNumberT readValue;
    logic memReadEnable;
    logic memWriteEnable;
    logic [PaddrWidth-1:0] memAddr;
    logic [31:0] memWriteData;

    logic [31:0] memory [logic [PaddrWidth-1:0]];
    pteT writeLog [$];
    int readCount = 0;
    int cycleCount = 0;
    integer seed = 32'h3e17_6196;
    logic reported = 1'b0;

    // Result of the last lookup
    logic lookupHit;
    logic lookupFault;
    physicalPageNumberT lookupValue;
    int lookupCycles;
    int lookupReads;
    int lookupWrites;

    Mmu #(
        .IndexWidth(2)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        reported = 1'b1;
        $display("TEST FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkPageNumber(input string name, input physicalPageNumberT actual,
            input physicalPageNumberT expected);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic checkPte(input string name, input pteT actual, input pteT expected);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // Memory model with a random read latency of 1 to 4 cycles
    initial begin
        logic [PaddrWidth-1:0] readAddr;
        int delay;
        memReadValid <= 1'b0;
        memReadData <= '0;
        forever begin
            @(posedge clk);
            if (memWriteEnable) begin
                memory[memAddr] = memWriteData;
                writeLog.push_back(memWriteData);
            end
            if (memReadEnable) begin
                readAddr = memAddr;
                readCount++;
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(posedge clk);
                memReadValid <= 1'b1;
                memReadData <= memory.exists(readAddr) ? memory[readAddr] : 32'h0;
                @(posedge clk);
                memReadValid <= 1'b0;
            end
        end
    end

    initial begin
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        failRun($sformatf("Run did not finish within %0d cycles", CycleLimit));
    end

    function automatic logic [PaddrWidth-1:0] pteAddress(input physicalPageNumberT base,
            input logic [9:0] index);
        return {base, 12'h000} + PaddrWidth'(index) * 4;
    endfunction

    task automatic placePte(input physicalPageNumberT base, input logic [9:0] index,
            input physicalPageNumberT ppn, input logic [7:0] flags);
        memory[pteAddress(base, index)] = {ppn, 2'b00, flags};
    endtask

    task automatic setContext(input Privilege privilege, input AddressTranslationMode mode,
            input logic sum, input logic mxr);
        @(posedge clk);
        csrPrivilege <= privilege;
        csrSatp <= {mode, 9'h000, RootPpn};
        csrSum <= sum;
        csrMxr <= mxr;
    endtask

    task automatic invalidateAll();
        @(posedge clk);
        invalidate <= 1'b1;
        @(posedge clk);
        invalidate <= 1'b0;
    endtask

    // Holds the lookup until hit or fault, sampled at the falling edge
    task automatic lookup(input virtualPageNumberT vpn, input MemoryAccessType accessType);
        int readsBefore;
        int writesBefore;
        readsBefore = readCount;
        writesBefore = writeLog.size();
        @(posedge clk);
        readEnable <= 1'b1;
        readKey <= vpn;
        readAccessType <= accessType;
        lookupCycles = 0;
        @(negedge clk);
        while (!hit && !fault) begin
            lookupCycles++;
            if (lookupCycles >= LookupTimeout) begin
                failRun($sformatf("Lookup of page %h got neither hit nor fault", vpn));
            end
            @(negedge clk);
        end
        lookupHit = hit;
        lookupFault = fault;
        lookupValue = readValue;
        lookupReads = readCount - readsBefore;
        lookupWrites = writeLog.size() - writesBefore;
        @(posedge clk);
        readEnable <= 1'b0;
    endtask

    task automatic expectTranslation(input virtualPageNumberT vpn,
            input MemoryAccessType accessType, input physicalPageNumberT ppn, input logic walk);
        lookup(vpn, accessType);
        checkFlag("hit", lookupHit, 1'b1);
        checkFlag("fault", lookupFault, 1'b0);
        checkPageNumber("readValue", lookupValue, ppn);
        checkFlag("memory read", lookupReads != 0, walk);
        if (!walk) begin
            checkFlag("same-cycle hit", lookupCycles == 0, 1'b1);
        end
    endtask

    task automatic expectFault(input virtualPageNumberT vpn, input MemoryAccessType accessType);
        lookup(vpn, accessType);
        checkFlag("hit", lookupHit, 1'b0);
        checkFlag("fault", lookupFault, 1'b1);
    endtask

    task automatic testBypass();
        virtualPageNumberT vpn;
        vpn = 20'habcde;
        setContext(Machine, Sv32, 1'b0, 1'b0);
        expectTranslation(vpn, Store, {2'b00, vpn}, 1'b0);
        checkFlag("memory write", lookupWrites != 0, 1'b0);
        setContext(Supervisor, Bare, 1'b0, 1'b0);
        expectTranslation(vpn, Load, {2'b00, vpn}, 1'b0);
        checkFlag("memory write", lookupWrites != 0, 1'b0);
    endtask

    task automatic testPage4k();
        virtualPageNumberT vpn;
        pteT accessedPte;
        vpn = {10'd1, 10'd5};
        accessedPte = {22'h012345, 2'b00, FlagValid | FlagRead | FlagWrite | FlagAccessed};
        placePte(TablePpn, 10'd5, 22'h012345, FlagValid | FlagRead | FlagWrite);
        setContext(Supervisor, Sv32, 1'b0, 1'b0);
        expectTranslation(vpn, Load, 22'h012345, 1'b1);
        checkFlag("write-back", lookupWrites == 1, 1'b1);
        checkPte("memWriteData", writeLog[$], accessedPte);
        // Write-back lands on the level-0 PTE
        checkPte("PTE in memory", memory[pteAddress(TablePpn, 10'd5)], accessedPte);
        expectTranslation(vpn, Load, 22'h012345, 1'b0);
    endtask

    task automatic testMegapage();
        placePte(RootPpn, 10'd2, {12'h0ab, 10'h000}, FlagValid | FlagRead | FlagAccessed);
        // Low page number bits set, so misaligned
        placePte(RootPpn, 10'd3, {12'h0ac, 10'h001}, FlagValid | FlagRead | FlagAccessed);
        expectTranslation({10'd2, 10'h123}, Load, {12'h0ab, 10'h123}, 1'b1);
        expectFault({10'd3, 10'h010}, Load);
        // Root slot 4 never written, so the PTE is invalid
        expectFault({10'd4, 10'h000}, Load);
    endtask

    task automatic testPermissions();
        virtualPageNumberT userPage;
        virtualPageNumberT superPage;
        virtualPageNumberT execPage;
        userPage = {10'd1, 10'd6};
        superPage = {10'd1, 10'd7};
        execPage = {10'd1, 10'd8};
        placePte(TablePpn, 10'd6, 22'h000600,
            FlagValid | FlagRead | FlagWrite | FlagUser | FlagAccessed | FlagDirty);
        placePte(TablePpn, 10'd7, 22'h000700,
            FlagValid | FlagRead | FlagWrite | FlagAccessed | FlagDirty);
        placePte(TablePpn, 10'd8, 22'h000800, FlagValid | FlagExec | FlagAccessed);
        invalidateAll();
        setContext(Supervisor, Sv32, 1'b0, 1'b0);
        expectFault(userPage, Load);
        setContext(Supervisor, Sv32, 1'b1, 1'b0);
        expectTranslation(userPage, Load, 22'h000600, 1'b0);
        setContext(User, Sv32, 1'b0, 1'b0);
        expectTranslation(userPage, Load, 22'h000600, 1'b0);
        expectFault(superPage, Load);
        setContext(Supervisor, Sv32, 1'b0, 1'b0);
        expectTranslation(superPage, Load, 22'h000700, 1'b0);
        expectFault(execPage, Load);
        setContext(Supervisor, Sv32, 1'b0, 1'b1);
        expectTranslation(execPage, Load, 22'h000800, 1'b0);
        expectTranslation(execPage, Instruction, 22'h000800, 1'b0);
        expectFault(superPage, Instruction);
    endtask

    task automatic testDirty();
        logic [7:0] flags;
        invalidateAll();
        setContext(Supervisor, Sv32, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            flags = FlagValid | FlagRead | FlagWrite | FlagAccessed | FlagDirty;
            // Last page starts clean and not yet accessed
            if (i == 3) begin
                flags = FlagValid | FlagRead | FlagWrite;
            end
            placePte(TablePpn, 10'(10 + i), PpnWidth'(32'ha00 + i), flags);
            expectTranslation({10'd1, 10'(10 + i)}, Load, PpnWidth'(32'ha00 + i), 1'b1);
        end
        expectTranslation({10'd1, 10'd13}, Store, 22'h000a03, 1'b1);
        checkPte("memWriteData", writeLog[$], {22'h000a03, 2'b00,
            FlagValid | FlagRead | FlagWrite | FlagAccessed | FlagDirty});
        expectTranslation({10'd1, 10'd13}, Store, 22'h000a03, 1'b0);
        for (int i = 0; i < 3; i++) begin
            expectTranslation({10'd1, 10'(10 + i)}, Load, PpnWidth'(32'ha00 + i), 1'b0);
        end
        // Index moved past the dirtied slot, so a new page takes the oldest one
        placePte(TablePpn, 10'd14, 22'h000a04,
            FlagValid | FlagRead | FlagWrite | FlagAccessed | FlagDirty);
        expectTranslation({10'd1, 10'd14}, Load, 22'h000a04, 1'b1);
        expectTranslation({10'd1, 10'd13}, Store, 22'h000a03, 1'b0);
    endtask

    task automatic testReplacement();
        invalidateAll();
        for (int i = 0; i < 5; i++) begin
            placePte(TablePpn, 10'(20 + i), PpnWidth'(32'h1000 + i),
                FlagValid | FlagRead | FlagWrite | FlagAccessed | FlagDirty);
            expectTranslation({10'd1, 10'(20 + i)}, Load, PpnWidth'(32'h1000 + i), 1'b1);
        end
        for (int i = 1; i < 5; i++) begin
            expectTranslation({10'd1, 10'(20 + i)}, Load, PpnWidth'(32'h1000 + i), 1'b0);
        end
        // First filled page was evicted by the fifth
        expectTranslation({10'd1, 10'd20}, Load, 22'h001000, 1'b1);
        invalidateAll();
        for (int i = 0; i < 5; i++) begin
            expectTranslation({10'd1, 10'(20 + i)}, Load, PpnWidth'(32'h1000 + i), 1'b1);
        end
    endtask

    initial begin
        rst <= 1'b1;
        readEnable <= 1'b0;
        readKey <= '0;
        readAccessType <= Load;
        csrSatp <= '0;
        csrPrivilege <= Machine;
        csrSum <= 1'b0;
        csrMxr <= 1'b0;
        invalidate <= 1'b0;
        // Root slot 1 points to the level-0 table
        placePte(RootPpn, 10'd1, TablePpn, FlagValid);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        testBypass();
        testPage4k();
        testMegapage();
        testPermissions();
        testDirty();
        testReplacement();
        reported = 1'b1;
        $display("TEST PASS");
        $finish;
    end

    // Run ended before any verdict
    final begin
        if (!reported) begin
            $display("TEST FAIL");
        end
    end

endmodule

/* verif/Mmu_assertions.sv */
module MmuAssertions import MmuTypes::*; (
    input logic clk,
    input logic rst,
    input logic hit,
    input logic fault,
    input csrSatpT csrSatp,
    input Privilege csrPrivilege,
    input logic invalidate,
    input logic memReadEnable,
    input logic memWriteEnable,
    input logic memReadValid,
    input logic tlbMiss,
    input logic tlbWriteEnable
);
    logic readOutstanding;
    // Walker left Idle and has not yet refilled
    logic walking;

    always_ff @(posedge clk) begin
        if (rst) begin
            readOutstanding <= 1'b0;
            walking <= 1'b0;
        end else begin
            if (memReadValid) begin
                readOutstanding <= 1'b0;
            end
            if (memReadEnable) begin
                readOutstanding <= 1'b1;
            end
            if (tlbWriteEnable) begin
                walking <= 1'b0;
            end else if (tlbMiss) begin
                walking <= 1'b1;
            end
        end
    end

    hitFaultExclusive: assert property (@(posedge clk) disable iff (rst)
        !(hit && fault))
        else $error("hit and fault are high in the same cycle");

    singleRead: assert property (@(posedge clk) disable iff (rst)
        memReadEnable |-> !readOutstanding)
        else $error("memory read issued while another read is outstanding");

    invalidateWhenIdle: assert property (@(posedge clk) disable iff (rst)
        invalidate |-> !walking)
        else $error("invalidate raised during a page walk");

    noAccessUntranslated: assert property (@(posedge clk) disable iff (rst)
        (csrPrivilege == Machine || csrSatp.mode == Bare) |-> !memReadEnable && !memWriteEnable)
        else $error("memory access while translation is off");

endmodule

bind Mmu MmuAssertions mmuChecks (
    .clk(clk),
    .rst(rst),
    .hit(hit),
    .fault(fault),
    .csrSatp(csrSatp),
    .csrPrivilege(csrPrivilege),
    .invalidate(invalidate),
    .memReadEnable(memReadEnable),
    .memWriteEnable(memWriteEnable),
    .memReadValid(memReadValid),
    .tlbMiss(tlbMiss),
    .tlbWriteEnable(tlbWriteEnable)
);

/* source/Mmu.sv */
module Mmu import MmuTypes::*; #(
    parameter int IndexWidth = 2
) (
    output logic hit,
    output logic fault,
    output physicalPageNumberT readValue,
    output logic memReadEnable,
    output logic memWriteEnable,
    output logic [PaddrWidth-1:0] memAddr,
    output logic [31:0] memWriteData,
    input logic readEnable,
    input virtualPageNumberT readKey,
    input MemoryAccessType readAccessType,
    input csrSatpT csrSatp,
    input Privilege csrPrivilege,
    input logic csrSum,
    input logic csrMxr,
    input logic invalidate,
    input logic memReadValid,
    input logic [31:0] memReadData,
    input logic clk,
    input logic rst
);
    logic tlbMiss;
    logic tlbWriteEnable;
    virtualPageNumberT tlbWriteKey;
    TlbEntry tlbWriteValue;

    Tlb #(
        .IndexWidth(IndexWidth)
    ) tlb (
        .hit(hit),
        .fault(fault),
        .readValue(readValue),
        .tlbMiss(tlbMiss),
        .readEnable(readEnable),
        .readKey(readKey),
        .readAccessType(readAccessType),
        .writeEnable(tlbWriteEnable),
        .writeKey(tlbWriteKey),
        .writeValue(tlbWriteValue),
        .csrSatp(csrSatp),
        .csrPrivilege(csrPrivilege),
        .csrSum(csrSum),
        .csrMxr(csrMxr),
        .invalidate(invalidate),
        .clk(clk),
        .rst(rst)
    );

    // Walker sees the same held lookup as the TLB
    PageWalker walker (
        .memReadEnable(memReadEnable),
        .memWriteEnable(memWriteEnable),
        .memAddr(memAddr),
        .memWriteData(memWriteData),
        .tlbWriteEnable(tlbWriteEnable),
        .tlbWriteKey(tlbWriteKey),
        .tlbWriteValue(tlbWriteValue),
        .tlbMiss(tlbMiss),
        .readKey(readKey),
        .readAccessType(readAccessType),
        .csrSatp(csrSatp),
        .memReadValid(memReadValid),
        .memReadData(memReadData),
        .clk(clk),
        .rst(rst)
    );

endmodule

/* source/PageWalker.sv */
module PageWalker import MmuTypes::*; (
    output logic memReadEnable,
    output logic memWriteEnable,
    output logic [PaddrWidth-1:0] memAddr,
    output logic [31:0] memWriteData,
    output logic tlbWriteEnable,
    output virtualPageNumberT tlbWriteKey,
    output TlbEntry tlbWriteValue,
    input logic tlbMiss,
    input virtualPageNumberT readKey,
    input MemoryAccessType readAccessType,
    input csrSatpT csrSatp,
    input logic memReadValid,
    input logic [31:0] memReadData,
    input logic clk,
    input logic rst
);
    typedef enum logic [2:0] {
        Idle,
        ReadRequest,
        ReadWait,
        WriteBack,
        Refill
    } walkStateT;

    walkStateT state;
    // High while the root table is being read
    logic levelOne;
    logic [PaddrWidth-1:0] pteAddr;
    pteT updatedPte;
    TlbEntry refillEntry;

    pteT memPte;
    pageFlagsT updatedFlags;
    logic pteIsPointer;
    logic pteFault;

    assign memPte = memReadData;

    // Decode of the PTE on the memory data bus
    always_comb begin
        pteIsPointer = memPte.flags.valid && !memPte.flags.read && !memPte.flags.execute;
        pteFault = !memPte.flags.valid
            || (memPte.flags.write && !memPte.flags.read)
            || (pteIsPointer && !levelOne)
            || (!pteIsPointer && levelOne && memPte.ppn.ppn0 != '0);
        updatedFlags = memPte.flags;
        updatedFlags.accessed = 1'b1;
        if (readAccessType == Store) begin
            updatedFlags.dirty = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            levelOne <= 1'b1;
        end else begin
            case (state)
                Idle: begin
                    if (tlbMiss) begin
                        state <= ReadRequest;
                        levelOne <= 1'b1;
                    end
                end
                ReadRequest: state <= ReadWait;
                ReadWait: begin
                    if (memReadValid) begin
                        if (pteFault) begin
                            state <= Refill;
                        end else if (pteIsPointer) begin
                            state <= ReadRequest;
                            levelOne <= 1'b0;
                        end else if (updatedFlags != memPte.flags) begin
                            state <= WriteBack;
                        end else begin
                            state <= Refill;
                        end
                    end
                end
                WriteBack: state <= Refill;
                default: state <= Idle;
            endcase
        end
    end

    // Walk address and refill data
    always_ff @(posedge clk) begin
        if (state == Idle) begin
            pteAddr <= {csrSatp.ppn, readKey.vpn1, 2'b00};
        end else if (state == ReadWait && memReadValid) begin
            if (pteIsPointer && !pteFault) begin
                pteAddr <= {memPte.ppn, readKey.vpn0, 2'b00};
            end
            updatedPte <= {memPte.ppn, memPte.rsw, updatedFlags};
            refillEntry.valid <= 1'b1;
            refillEntry.fault <= pteFault;
            refillEntry.flags <= updatedFlags;
            // Megapage keeps vpn0 as the low page number bits
            refillEntry.pageNumber <= levelOne ? {memPte.ppn.ppn1, readKey.vpn0} : memPte.ppn;
        end
    end

    assign memReadEnable = (state == ReadRequest);
    assign memWriteEnable = (state == WriteBack);
    assign memAddr = pteAddr;
    assign memWriteData = updatedPte;
    assign tlbWriteEnable = (state == Refill);
    assign tlbWriteKey = readKey;
    assign tlbWriteValue = refillEntry;

endmodule

/* source/Tlb.sv */
module Tlb import MmuTypes::*; #(
    parameter int IndexWidth
) (
    output logic hit,
    output logic fault,
    output physicalPageNumberT readValue,
    output logic tlbMiss,
    input logic readEnable,
    input virtualPageNumberT readKey,
    input MemoryAccessType readAccessType,
    input logic writeEnable,
    input virtualPageNumberT writeKey,
    input TlbEntry writeValue,
    input csrSatpT csrSatp,
    input Privilege csrPrivilege,
    input logic csrSum,
    input logic csrMxr,
    input logic invalidate,
    input logic clk,
    input logic rst
);
    function automatic logic accessDenied(TlbEntry entry, MemoryAccessType accessType,
            Privilege privilege, logic sum, logic mxr);
        logic denied;
        denied = 1'b0;
        if (entry.fault) begin
            denied = 1'b1;
        end else if (privilege == Supervisor && entry.flags.user && !sum) begin
            denied = 1'b1;
        end else if (privilege == User && !entry.flags.user) begin
            denied = 1'b1;
        end else begin
            case (accessType)
                Instruction: denied = !entry.flags.execute;
                // MXR makes execute-only pages readable
                Load: denied = !(entry.flags.read || (mxr && entry.flags.execute));
                Store: denied = !entry.flags.write;
                default: denied = 1'b1;
            endcase
        end
        return denied;
    endfunction

    logic camHit;
    TlbEntry camValue;
    logic [IndexWidth-1:0] camIndex;
    logic [IndexWidth-1:0] writeIndex;
    logic [IndexWidth-1:0] nextWriteIndex;
    logic translationOn;
    logic entryHit;
    logic entryFault;
    logic dirtyNeeded;

    FlipFlopCam #(
        .IndexWidth(IndexWidth)
    ) cam (
        .hit(camHit),
        .readValue(camValue),
        .readIndex(camIndex),
        .readKey(readKey),
        .writeEnable(writeEnable),
        .writeIndex(writeIndex),
        .writeKey(writeKey),
        .writeValue(writeValue),
        .clear(invalidate),
        .clk(clk),
        .rst(rst)
    );

    assign translationOn = (csrPrivilege != Machine) && (csrSatp.mode == Sv32);
    assign entryHit = camHit && camValue.valid;
    assign entryFault = accessDenied(camValue, readAccessType, csrPrivilege, csrSum, csrMxr);
    // Store to a clean page needs a walk to set dirty
    assign dirtyNeeded = (readAccessType == Store) && !camValue.flags.dirty;

    always_comb begin
        if (translationOn) begin
            hit = readEnable && entryHit && !entryFault && !dirtyNeeded;
            fault = readEnable && entryHit && entryFault;
            readValue = camValue.pageNumber;
        end else begin
            hit = readEnable;
            fault = 1'b0;
            readValue = {{(PpnWidth - VpnWidth){1'b0}}, readKey};
        end
    end

    assign tlbMiss = readEnable && translationOn && !hit && !fault;

    // Round-robin, except that a clean entry is replaced in place
    always_comb begin
        if (writeEnable) begin
            nextWriteIndex = writeIndex + IndexWidth'(1);
        end else if (readEnable && translationOn && entryHit && !entryFault && dirtyNeeded) begin
            nextWriteIndex = camIndex;
        end else begin
            nextWriteIndex = writeIndex;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writeIndex <= '0;
        end else begin
            writeIndex <= nextWriteIndex;
        end
    end

endmodule

/* source/FlipFlopCam.sv */
module FlipFlopCam import MmuTypes::*; #(
    parameter int IndexWidth
) (
    output logic hit,
    output TlbEntry readValue,
    output logic [IndexWidth-1:0] readIndex,
    input virtualPageNumberT readKey,
    input logic writeEnable,
    input logic [IndexWidth-1:0] writeIndex,
    input virtualPageNumberT writeKey,
    input TlbEntry writeValue,
    input logic clear,
    input logic clk,
    input logic rst
);
    localparam int Entries = 1 << IndexWidth;

    virtualPageNumberT keys [Entries];
    TlbEntry values [Entries];
    logic [Entries-1:0] slotValid;

    // Parallel match over all slots
    always_comb begin
        hit = 1'b0;
        readValue = '0;
        readIndex = '0;
        for (int i = 0; i < Entries; i++) begin
            if (slotValid[i] && keys[i] == readKey) begin
                hit = 1'b1;
                readValue = values[i];
                readIndex = IndexWidth'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            slotValid <= '0;
        end else if (writeEnable) begin
            slotValid[writeIndex] <= 1'b1;
        end
    end

    // Slot contents
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            keys[writeIndex] <= writeKey;
            values[writeIndex] <= writeValue;
        end
    end

endmodule

/* source/MmuTypes.sv */
package MmuTypes;

    localparam int VaddrWidth = 32;
    localparam int PaddrWidth = 34;
    localparam int PageOffsetWidth = 12;
    localparam int VpnWidth = VaddrWidth - PageOffsetWidth;
    localparam int PpnWidth = PaddrWidth - PageOffsetWidth;

    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } virtualPageNumberT;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0] ppn0;
    } physicalPageNumberT;

    // RISC-V privilege encoding, 2'b10 is reserved
    typedef enum logic [1:0] {
        User = 2'b00,
        Supervisor = 2'b01,
        Machine = 2'b11
    } Privilege;

    typedef enum logic [1:0] {
        Instruction = 2'b00,
        Load = 2'b01,
        Store = 2'b10
    } MemoryAccessType;

    typedef enum logic {
        Bare = 1'b0,
        Sv32 = 1'b1
    } AddressTranslationMode;

    typedef struct packed {
        AddressTranslationMode mode;
        logic [8:0] asid;
        physicalPageNumberT ppn;
    } csrSatpT;

    // Same bit order as the low byte of a PTE
    typedef struct packed {
        logic dirty;
        logic accessed;
        logic isGlobal;
        logic user;
        logic execute;
        logic write;
        logic read;
        logic valid;
    } pageFlagsT;

    typedef struct packed {
        logic valid;
        logic fault;
        pageFlagsT flags;
        physicalPageNumberT pageNumber;
    } TlbEntry;

    typedef struct packed {
        physicalPageNumberT ppn;
        logic [1:0] rsw;
        pageFlagsT flags;
    } pteT;

endpackage
